// File: hdl/lsu_params.svh
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// data and address width
`define LSU_XLEN 64

// number of load lanes, a power of two (2, 4 or 8)
`define LSU_LANES 4

// destination register tag width
`define LSU_TAG_W 5

// kind field width
`define LSU_KIND_W 3

// bytes per bus word
`define LSU_BYTES (`LSU_XLEN / 8)

// low address bits that select a byte within the word
`define LSU_OFF_W $clog2(`LSU_BYTES)

// bits needed to name one lane
`define LSU_IDX_W $clog2(`LSU_LANES)

`endif

// File: hdl/lsu_types_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package lsu_types_pkg;

    // one bus or register word
    typedef logic [`LSU_XLEN-1:0] xlen_t;

    // byte address
    typedef logic [`LSU_XLEN-1:0] addr_t;

    // destination register tag
    typedef logic [`LSU_TAG_W-1:0] tag_t;

    // load kinds, U variants zero extend
    typedef enum logic [`LSU_KIND_W-1:0] {
        LD_B  = 3'd0,
        LD_BU = 3'd1,
        LD_H  = 3'd2,
        LD_HU = 3'd3,
        LD_W  = 3'd4,
        LD_WU = 3'd5,
        LD_D  = 3'd6
    } load_kind_t;

    // per-lane FSM
    typedef enum logic [1:0] {
        L_IDLE = 2'd0,
        L_BUS  = 2'd1,
        L_DONE = 2'd2
    } lane_state_t;

endpackage

`default_nettype wire

// File: hdl/wb_bus_pkg.sv
`default_nettype none

`include "lsu_params.svh"

package wb_bus_pkg;

    // one bit per byte of the bus word
    typedef logic [`LSU_BYTES-1:0] wb_sel_t;

    // names a single lane
    typedef logic [`LSU_IDX_W-1:0] lane_idx_t;

    // one bit per lane, used for grants and flag vectors
    typedef logic [`LSU_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

// File: hdl/lsu_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// request hand-off from the dispatcher to one lane
interface load_req_if import lsu_types_pkg::*; ();

    logic       go;
    addr_t      base;
    addr_t      offset;
    load_kind_t kind;
    tag_t       tag;
    logic       idle;

    modport dispatcher (
        output go,
        output base,
        output offset,
        output kind,
        output tag,
        input  idle
    );

    modport lane (
        input  go,
        input  base,
        input  offset,
        input  kind,
        input  tag,
        output idle
    );

endinterface

// one lane's path to the shared Wishbone master
interface lane_bus_if import lsu_types_pkg::*, wb_bus_pkg::*; ();

    logic    bus_req;
    addr_t   adr;
    wb_sel_t sel;
    // read data after extraction and extension by kind
    xlen_t   rdata_kind;
    tag_t    tag;
    logic    ack;
    xlen_t   rdata;

    modport lane (
        output bus_req,
        output adr,
        output sel,
        output rdata_kind,
        output tag,
        input  ack,
        input  rdata
    );

    modport arbiter (
        input  bus_req,
        input  adr,
        input  sel,
        input  rdata_kind,
        input  tag,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

// File: hdl/load_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module load_dispatch import lsu_types_pkg::*, wb_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  addr_t                 req_base,
    input  addr_t                 req_offset,
    input  load_kind_t            req_kind,
    input  tag_t                  req_tag,
    output logic                  req_ready,
    load_req_if.dispatcher        lanes [`LSU_LANES]
);

    lane_mask_t idle_vec;
    lane_mask_t go_vec;
    lane_idx_t  pick;
    logic       armed;
    logic       take;

    // flatten the idle flags, broadcast the request fields
    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_lane
        assign idle_vec[i]     = lanes[i].idle;
        assign lanes[i].go     = go_vec[i];
        assign lanes[i].base   = req_base;
        assign lanes[i].offset = req_offset;
        assign lanes[i].kind   = req_kind;
        assign lanes[i].tag    = req_tag;
    end

    // lowest numbered idle lane wins
    always_comb begin
        pick = '0;
        for (int i = `LSU_LANES - 1; i >= 0; i--) begin
            if (idle_vec[i]) begin
                pick = lane_idx_t'(i);
            end
        end
    end

    // lanes report idle from the first edge after reset on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
        end
    end

    assign req_ready = armed & (|idle_vec);
    assign take      = req_valid & req_ready;

    // go goes to the picked lane only
    assign go_vec = take ? (lane_mask_t'(1) << pick) : '0;

endmodule

`default_nettype wire

// File: hdl/load_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module load_lane import lsu_types_pkg::*, wb_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    load_req_if.lane req,
    lane_bus_if.lane bus
);

    lane_state_t            state;
    lane_state_t            state_nxt;
    addr_t                  addr_q;
    load_kind_t             kind_q;
    tag_t                   tag_q;
    xlen_t                  result_q;
    logic [`LSU_OFF_W-1:0]  off;
    wb_sel_t                size_mask;
    xlen_t                  shifted;
    xlen_t                  extended;

    // byte position of the access inside the word
    assign off = addr_q[`LSU_OFF_W-1:0];

    always_comb begin
        state_nxt = state;
        case (state)
            L_IDLE: begin
                if (req.go) begin
                    state_nxt = L_BUS;
                end
            end
            L_BUS: begin
                if (bus.ack) begin
                    state_nxt = L_DONE;
                end
            end
            // result is on the return path for this one cycle
            L_DONE: begin
                state_nxt = L_IDLE;
            end
            default: begin
                state_nxt = L_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= L_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // request fields and result
    always_ff @(posedge clk) begin
        if (req.go && state == L_IDLE) begin
            addr_q <= req.base + req.offset;
            kind_q <= req.kind;
            tag_q  <= req.tag;
        end
        if (bus.ack) begin
            result_q <= extended;
        end
    end

    // bytes covered by each access size
    always_comb begin
        case (kind_q)
            LD_B, LD_BU: size_mask = wb_sel_t'(8'h01);
            LD_H, LD_HU: size_mask = wb_sel_t'(8'h03);
            LD_W, LD_WU: size_mask = wb_sel_t'(8'h0f);
            default:     size_mask = '1;
        endcase
    end

    // move the addressed bytes down to bit 0
    assign shifted = bus.rdata >> {off, 3'b000};

    always_comb begin
        case (kind_q)
            LD_B:    extended = {{(`LSU_XLEN - 8){shifted[7]}}, shifted[7:0]};
            LD_BU:   extended = {{(`LSU_XLEN - 8){1'b0}}, shifted[7:0]};
            LD_H:    extended = {{(`LSU_XLEN - 16){shifted[15]}}, shifted[15:0]};
            LD_HU:   extended = {{(`LSU_XLEN - 16){1'b0}}, shifted[15:0]};
            LD_W:    extended = {{(`LSU_XLEN - 32){shifted[31]}}, shifted[31:0]};
            LD_WU:   extended = {{(`LSU_XLEN - 32){1'b0}}, shifted[31:0]};
            default: extended = shifted;
        endcase
    end

    assign req.idle = (state == L_IDLE);

    // aligned word address, held for the whole bus cycle
    assign bus.bus_req    = (state == L_BUS);
    assign bus.adr        = {addr_q[`LSU_XLEN-1:`LSU_OFF_W], {`LSU_OFF_W{1'b0}}};
    assign bus.sel        = size_mask << off;
    assign bus.rdata_kind = result_q;
    assign bus.tag        = tag_q;

endmodule

`default_nettype wire

// File: hdl/wb_lane_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module wb_lane_arbiter import lsu_types_pkg::*, wb_bus_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    lane_bus_if.arbiter    lanes [`LSU_LANES],
    output logic           wb_cyc,
    output logic           wb_stb,
    output addr_t          wb_adr,
    output wb_sel_t        wb_sel,
    input  xlen_t          wb_dat_i,
    input  logic           wb_ack,
    output logic           res_valid,
    output xlen_t          res_data,
    output tag_t           res_tag
);

    lane_mask_t req_vec;
    lane_mask_t grant_oh;
    addr_t      adr_arr  [`LSU_LANES];
    wb_sel_t    sel_arr  [`LSU_LANES];
    xlen_t      data_arr [`LSU_LANES];
    tag_t       tag_arr  [`LSU_LANES];
    lane_idx_t  rr_ptr;
    lane_idx_t  grant;
    lane_idx_t  pick;
    lane_idx_t  done_idx;
    logic       found;
    logic       busy;
    logic       ack_hit;

    for (genvar i = 0; i < `LSU_LANES; i++) begin : g_lane
        assign req_vec[i]     = lanes[i].bus_req;
        assign adr_arr[i]     = lanes[i].adr;
        assign sel_arr[i]     = lanes[i].sel;
        assign data_arr[i]    = lanes[i].rdata_kind;
        assign tag_arr[i]     = lanes[i].tag;
        assign lanes[i].ack   = ack_hit & grant_oh[i];
        assign lanes[i].rdata = wb_dat_i;
    end

    // round robin search starting at rr_ptr
    always_comb begin
        lane_idx_t cand;
        pick  = '0;
        found = 1'b0;
        cand  = '0;
        for (int i = 0; i < `LSU_LANES; i++) begin
            cand = lane_idx_t'(rr_ptr + lane_idx_t'(i));
            if (!found && req_vec[cand]) begin
                pick  = cand;
                found = 1'b1;
            end
        end
    end

    assign ack_hit  = busy & wb_ack;
    assign grant_oh = lane_mask_t'(1) << grant;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            grant  <= '0;
            rr_ptr <= '0;
        end else if (!busy) begin
            if (found) begin
                busy   <= 1'b1;
                grant  <= pick;
                rr_ptr <= pick + 1'b1;
            end
        end else if (wb_ack) begin
            busy <= 1'b0;
        end
    end

    // one wishbone cycle per grant
    assign wb_cyc = busy;
    assign wb_stb = busy;
    assign wb_adr = adr_arr[grant];
    assign wb_sel = sel_arr[grant];

    // result shows the cycle after ack, lane sits in L_DONE then
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            done_idx  <= '0;
        end else begin
            res_valid <= ack_hit;
            if (ack_hit) begin
                done_idx <= grant;
            end
        end
    end

    assign res_data = data_arr[done_idx];
    assign res_tag  = tag_arr[done_idx];

endmodule

`default_nettype wire

// File: hdl/load_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module load_unit_top import lsu_types_pkg::*, wb_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    input  addr_t      req_base,
    input  addr_t      req_offset,
    input  load_kind_t req_kind,
    input  tag_t       req_tag,
    output logic       req_ready,
    output logic       wb_cyc,
    output logic       wb_stb,
    output addr_t      wb_adr,
    output wb_sel_t    wb_sel,
    input  xlen_t      wb_dat_i,
    input  logic       wb_ack,
    output logic       res_valid,
    output xlen_t      res_data,
    output tag_t       res_tag
);

    // one request link and one bus link per lane
    load_req_if req_ifs [`LSU_LANES] ();
    lane_bus_if bus_ifs [`LSU_LANES] ();

    load_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_base   (req_base),
        .req_offset (req_offset),
        .req_kind   (req_kind),
        .req_tag    (req_tag),
        .req_ready  (req_ready),
        .lanes      (req_ifs)
    );

    for (genvar g = 0; g < `LSU_LANES; g++) begin : g_lanes
        load_lane u_lane (
            .clk   (clk),
            .rst_n (rst_n),
            .req   (req_ifs[g]),
            .bus   (bus_ifs[g])
        );
    end

    wb_lane_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .lanes     (bus_ifs),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_adr    (wb_adr),
        .wb_sel    (wb_sel),
        .wb_dat_i  (wb_dat_i),
        .wb_ack    (wb_ack),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_tag   (res_tag)
    );

endmodule

`default_nettype wire

// File: verification/load_unit_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit_asserts import lsu_types_pkg::*, wb_bus_pkg::*; (
    input logic    clk,
    input logic    rst_n,
    input logic    req_ready,
    input logic    wb_cyc,
    input logic    wb_stb,
    input addr_t   wb_adr,
    input wb_sel_t wb_sel,
    input logic    wb_ack,
    input logic    res_valid
);

    int fail_cnt = 0;

    task automatic note_fail(input string what);
        $error("%s", what);
        fail_cnt++;
    endtask

    // bus and result stay quiet while in reset
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !wb_cyc && !wb_stb && !res_valid)
        else note_fail("wb_cyc, wb_stb or res_valid high during reset");

    a_cyc_stb: assert property (@(posedge clk) disable iff (!rst_n) wb_cyc == wb_stb)
        else note_fail("wb_cyc and wb_stb differ");

    // classic cycle holds until ack
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc && !wb_ack |=> wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_sel))
        else note_fail("bus cycle dropped or changed before wb_ack");

    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        wb_cyc |-> wb_adr[2:0] == 3'b000 && wb_sel != '0)
        else note_fail("wb_adr not word aligned or wb_sel empty");

    a_res_pulse: assert property (@(posedge clk) disable iff (!rst_n) res_valid |=> !res_valid)
        else note_fail("res_valid held for two cycles");

    // the finishing lane is free right after its result
    a_ready_back: assert property (@(posedge clk) disable iff (!rst_n) res_valid |=> req_ready)
        else note_fail("req_ready still low after a result");

endmodule

bind load_unit_top load_unit_asserts u_asserts (.*);

`default_nettype wire

// File: verification/load_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_params.svh"

module load_unit_tb import lsu_types_pkg::*, wb_bus_pkg::*; ();

    localparam int    N_REQ     = 64;
    localparam int    MAX_CYCLE = N_REQ * 20;
    localparam int    N_TAGS    = 1 << `LSU_TAG_W;
    localparam xlen_t PATTERN   = 64'ha5c3_0f96_5a3c_f069;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    addr_t      req_base;
    addr_t      req_offset;
    load_kind_t req_kind;
    tag_t       req_tag;
    logic       req_ready;
    logic       wb_cyc;
    logic       wb_stb;
    addr_t      wb_adr;
    wb_sel_t    wb_sel;
    xlen_t      wb_dat_i;
    logic       wb_ack;
    logic       res_valid;
    xlen_t      res_data;
    tag_t       res_tag;

    logic [15:0] lfsr = 16'd3;
    logic        pend     [N_TAGS];
    xlen_t       exp_data [N_TAGS];
    addr_t       exp_adr  [N_TAGS];
    wb_sel_t     exp_sel  [N_TAGS];
    int          n_pend;
    int          n_sent;
    int          n_done;
    int          cycles;
    int          ack_wait;
    int          err_data;
    int          err_flow;
    logic        offer;
    logic        saw_full;

    load_unit_top u_dut (.*);

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int size_of(input load_kind_t k);
        case (k)
            LD_B, LD_BU: return 1;
            LD_H, LD_HU: return 2;
            LD_W, LD_WU: return 4;
            default:     return 8;
        endcase
    endfunction

    // memory content is a function of the word address
    function automatic xlen_t predict(input addr_t a, input load_kind_t k);
        xlen_t v;
        xlen_t keep;
        int    n;
        n = size_of(k);
        v = ((a & ~xlen_t'(7)) ^ PATTERN) >> (8 * a[2:0]);
        if (n < 8) begin
            keep = (xlen_t'(1) << (8 * n)) - 1;
            if (v[8*n-1] && k inside {LD_B, LD_H, LD_W}) begin
                v = v | ~keep;
            end else begin
                v = v & keep;
            end
        end
        return v;
    endfunction

    // first 56 requests sweep kind and byte offset and the rest are random
    task automatic next_request();
        int         k;
        int         n;
        logic [2:0] b;
        tag_t       t;
        if (n_sent < 56) begin
            k = n_sent % 7;
            n = size_of(load_kind_t'(k));
            b = 3'((n_sent / 7) * n);
        end else begin
            k = rand_bits(3) % 7;
            n = size_of(load_kind_t'(k));
            b = 3'(rand_bits(3) & ~(n - 1));
        end
        t = tag_t'(rand_bits(`LSU_TAG_W));
        while (pend[t]) begin
            t = t + 1'b1;
        end
        req_kind   = load_kind_t'(k);
        req_tag    = t;
        req_base   = ((xlen_t'(rand_bits(32)) << 32) | xlen_t'(rand_bits(29))) << 3;
        req_offset = (xlen_t'(rand_bits(2)) << 3) | xlen_t'(b);
    endtask

    task automatic accept_request();
        addr_t a;
        int    n;
        a = req_base + req_offset;
        n = size_of(req_kind);
        pend[req_tag]     = 1'b1;
        exp_data[req_tag] = predict(a, req_kind);
        exp_adr[req_tag]  = a & ~xlen_t'(7);
        exp_sel[req_tag]  = wb_sel_t'(((1 << n) - 1) << a[2:0]);
        n_pend++;
        n_sent++;
    endtask

    task automatic check_result();
        if (res_valid) begin
            a_tag: assert (pend[res_tag]) else begin
                err_flow++;
                $display("result returned for tag %0d which is not in flight", res_tag);
            end
            a_data: assert (res_data === exp_data[res_tag]) else begin
                err_data++;
                $display("MISMATCH res_data %h expected %h tag %h",
                         res_data, exp_data[res_tag], res_tag);
            end
            if (pend[res_tag]) begin
                n_pend--;
            end
            pend[res_tag] = 1'b0;
            n_done++;
        end
    endtask

    // memory model acks after a random 0 to 3 cycle wait
    task automatic serve_bus();
        logic hit;
        hit = 1'b0;
        if (wb_ack) begin
            wb_ack = 1'b0;
        end else if (wb_cyc) begin
            if (ack_wait == 0) begin
                for (int t = 0; t < N_TAGS; t++) begin
                    if (pend[t] && exp_adr[t] == wb_adr && exp_sel[t] == wb_sel) begin
                        hit = 1'b1;
                    end
                end
                a_sel: assert (hit) else begin
                    err_flow++;
                    $display("MISMATCH wb_sel %h wb_adr %h fit no load in flight",
                             wb_sel, wb_adr);
                end
                wb_dat_i = wb_adr ^ PATTERN;
                wb_ack   = 1'b1;
                ack_wait = rand_bits(2);
            end else begin
                ack_wait--;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= MAX_CYCLE) begin
                $display("timeout after %0d cycles with %0d results back", cycles, n_done);
                $display(">>> FAIL");
                $finish;
            end
        end
    end

    initial begin
        int gap;
        int total;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_base   = '0;
        req_offset = '0;
        req_kind   = LD_B;
        req_tag    = '0;
        wb_dat_i   = '0;
        wb_ack     = 1'b0;
        n_pend     = 0;
        n_sent     = 0;
        n_done     = 0;
        err_data   = 0;
        err_flow   = 0;
        gap        = 0;
        offer      = 1'b0;
        saw_full   = 1'b0;
        ack_wait   = rand_bits(2);
        for (int t = 0; t < N_TAGS; t++) begin
            pend[t] = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        while (n_done < N_REQ) begin
            if (offer) begin
                accept_request();
                req_valid = 1'b0;
                gap = rand_bits(1);
            end
            // ready low only with every lane holding a load
            if (!req_ready) begin
                saw_full = 1'b1;
                a_full: assert (n_pend == `LSU_LANES) else begin
                    err_flow++;
                    $display("req_ready low with only %0d loads in flight", n_pend);
                end
            end
            check_result();
            serve_bus();
            if (!req_valid && n_sent < N_REQ) begin
                if (gap == 0) begin
                    next_request();
                    req_valid = 1'b1;
                end else begin
                    gap--;
                end
            end
            offer = req_valid && req_ready;
            @(negedge clk);
        end
        a_drained: assert (n_pend == 0) else begin
            err_flow++;
            $display("%0d loads never returned a result", n_pend);
        end
        a_filled: assert (saw_full) else begin
            err_flow++;
            $display("req_ready never dropped, lanes were not all busy at once");
        end
        total = err_data + err_flow + u_dut.u_asserts.fail_cnt;
        $display("errors: data %0d, flow %0d, protocol %0d",
                 err_data, err_flow, u_dut.u_asserts.fail_cnt);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/lsu_types_pkg.sv
hdl/wb_bus_pkg.sv
hdl/lsu_ifs.sv
hdl/load_dispatch.sv
hdl/load_lane.sv
hdl/wb_lane_arbiter.sv
hdl/load_unit_top.sv
verification/load_unit_asserts.sv
verification/load_unit_tb.sv
